//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal
TOP       ?= acsMultiHTb
FILELIST  ?= acsMultiH.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)Sim
	./obj_dir/$(TOP)Sim | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- acsMultiH.f
src/cpmDemodPkg.sv
src/rotatorTablePkg.sv
src/acsStreamIfs.sv
src/branchSequencer.sv
src/phaseRotator.sv
src/branchCollector.sv
src/addCompareSelect.sv
src/acsMultiH.sv
verif/acsMultiH_properties.sv
verif/acsMultiHTb.sv

//--- src/acsMultiH.sv
`timescale 1ns/1ps

module acsMultiH #(
   parameter cpmDemodPkg::phaseIdx [cpmDemodPkg::NUM_BRANCHES-1:0] PHASE45 = '0,
   parameter cpmDemodPkg::phaseIdx [cpmDemodPkg::NUM_BRANCHES-1:0] PHASE54 = '0
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  symEn,
   input  logic                  symEnEven,
   input  cpmDemodPkg::rotAngle  tilt,
   input  cpmDemodPkg::mfSample  mfI_45_0, mfI_45_1, mfI_45_2, mfI_45_3,
   input  cpmDemodPkg::mfSample  mfI_54_0, mfI_54_1, mfI_54_2, mfI_54_3,
   input  cpmDemodPkg::mfSample  mfQ_45_0, mfQ_45_1, mfQ_45_2, mfQ_45_3,
   input  cpmDemodPkg::mfSample  mfQ_54_0, mfQ_54_1, mfQ_54_2, mfQ_54_3,
   input  cpmDemodPkg::acsMetric accMet_45_0, accMet_45_1, accMet_45_2, accMet_45_3,
   input  cpmDemodPkg::acsMetric accMet_54_0, accMet_54_1, accMet_54_2, accMet_54_3,
   input  logic                  normalizeIn,
   output cpmDemodPkg::branchIdx selOut,
   output cpmDemodPkg::rotSample iOut,
   output cpmDemodPkg::rotSample qOut,
   output cpmDemodPkg::acsMetric accMetOut,
   output logic                  normalizeOut,
   output logic                  symEnOut
);

   localparam int NB = cpmDemodPkg::NUM_BRANCHES;

   // per-branch ports gathered into arrays, index is the branch number
   cpmDemodPkg::mfSample  mfI45 [NB];
   cpmDemodPkg::mfSample  mfI54 [NB];
   cpmDemodPkg::mfSample  mfQ45 [NB];
   cpmDemodPkg::mfSample  mfQ54 [NB];
   cpmDemodPkg::acsMetric accMet45 [NB];
   cpmDemodPkg::acsMetric accMet54 [NB];

   assign mfI45    = '{mfI_45_0, mfI_45_1, mfI_45_2, mfI_45_3};
   assign mfI54    = '{mfI_54_0, mfI_54_1, mfI_54_2, mfI_54_3};
   assign mfQ45    = '{mfQ_45_0, mfQ_45_1, mfQ_45_2, mfQ_45_3};
   assign mfQ54    = '{mfQ_54_0, mfQ_54_1, mfQ_54_2, mfQ_54_3};
   assign accMet45 = '{accMet_45_0, accMet_45_1, accMet_45_2, accMet_45_3};
   assign accMet54 = '{accMet_54_0, accMet_54_1, accMet_54_2, accMet_54_3};

   // serial branches in, rotated branches out, then the reassembled frame
   rotInIf       rotIn ();
   rotOutIf      rotOut ();
   branchFrameIf frame ();

   branchSequencer #(
      .PHASE45 (PHASE45),
      .PHASE54 (PHASE54)
   ) u_branchSequencer (
      .clk       (clk),
      .reset     (reset),
      .symEn     (symEn),
      .symEnEven (symEnEven),
      .tilt      (tilt),
      .mfI45     (mfI45),
      .mfI54     (mfI54),
      .mfQ45     (mfQ45),
      .mfQ54     (mfQ54),
      .rotIn     (rotIn.source)
   );

   phaseRotator u_phaseRotator (
      .clk    (clk),
      .reset  (reset),
      .rotIn  (rotIn.sink),
      .rotOut (rotOut.source)
   );

   branchCollector u_branchCollector (
      .clk    (clk),
      .reset  (reset),
      .rotOut (rotOut.sink),
      .frame  (frame.source)
   );

   addCompareSelect u_addCompareSelect (
      .clk          (clk),
      .reset        (reset),
      .frame        (frame.sink),
      .normalizeIn  (normalizeIn),
      .accMet45     (accMet45),
      .accMet54     (accMet54),
      .selOut       (selOut),
      .iOut         (iOut),
      .qOut         (qOut),
      .accMetOut    (accMetOut),
      .normalizeOut (normalizeOut),
      .symEnOut     (symEnOut)
   );

endmodule

//--- src/acsStreamIfs.sv
`timescale 1ns/1ps

// one branch per cycle from the sequencer into the rotator
interface rotInIf;
   logic                  valid;
   cpmDemodPkg::branchIdx branch;
   logic                  parity;
   cpmDemodPkg::rotSample i;
   cpmDemodPkg::rotSample q;
   cpmDemodPkg::rotAngle  angle;

   modport source (output valid, branch, parity, i, q, angle);
   modport sink   (input  valid, branch, parity, i, q, angle);
endinterface

// rotated branches leaving the rotator, still tagged with their branch number
interface rotOutIf;
   logic                  valid;
   cpmDemodPkg::branchIdx branch;
   logic                  parity;
   cpmDemodPkg::rotSample i;
   cpmDemodPkg::rotSample q;

   modport source (output valid, branch, parity, i, q);
   modport sink   (input  valid, branch, parity, i, q);
endinterface

// all four rotated branches of a symbol side by side
// ready is a single-cycle pulse, the arrays stay put until the next frame
interface branchFrameIf;
   logic                  ready;
   logic                  parity;
   cpmDemodPkg::rotSample iBranch [cpmDemodPkg::NUM_BRANCHES];
   cpmDemodPkg::rotSample qBranch [cpmDemodPkg::NUM_BRANCHES];

   modport source (output ready, parity, iBranch, qBranch);
   modport sink   (input  ready, parity, iBranch, qBranch);
endinterface

//--- src/addCompareSelect.sv
`timescale 1ns/1ps

module addCompareSelect (
   input  logic                  clk,
   input  logic                  reset,
   branchFrameIf.sink            frame,
   input  logic                  normalizeIn,
   input  cpmDemodPkg::acsMetric accMet45 [cpmDemodPkg::NUM_BRANCHES],
   input  cpmDemodPkg::acsMetric accMet54 [cpmDemodPkg::NUM_BRANCHES],
   output cpmDemodPkg::branchIdx selOut,
   output cpmDemodPkg::rotSample iOut,
   output cpmDemodPkg::rotSample qOut,
   output cpmDemodPkg::acsMetric accMetOut,
   output logic                  normalizeOut,
   output logic                  symEnOut
);

   localparam int NB = cpmDemodPkg::NUM_BRANCHES;
   localparam int AB = cpmDemodPkg::ACS_BITS;
   // the offset taken off a metric that is about to overflow
   localparam logic signed [AB:0] NORM_OFFSET = (AB + 1)'(2 ** (AB - 3));

   cpmDemodPkg::acsMetric metSel [NB];
   cpmDemodPkg::acsMetric sums [NB];
   cpmDemodPkg::acsMetric bestSum;
   cpmDemodPkg::branchIdx bestIdx;
   cpmDemodPkg::acsMetric bestMetric;

   // best metric less the offset, one bit wider to keep the true sign
   logic signed [AB:0] normDiff;

   always_comb begin
      for (int k = 0; k < NB; k++) begin
         // the frame parity decides which metric set the branches extend
         metSel[k] = frame.parity ? accMet54[k] : accMet45[k];
         // sign-extend the rotated I and add, the sum wraps like the metric
         sums[k] = cpmDemodPkg::acsMetric'(frame.iBranch[k]) + metSel[k];
      end
      // a strict greater-than keeps the lowest index on ties
      bestSum = sums[0];
      bestIdx = '0;
      for (int k = 1; k < NB; k++) begin
         if (sums[k] > bestSum) begin
            bestSum = sums[k];
            bestIdx = cpmDemodPkg::branchIdx'(k);
         end
      end
   end

   // survivor registers load once per frame and hold until the next one
   always_ff @(posedge clk) begin
      if (reset) begin
         selOut     <= '0;
         iOut       <= '0;
         qOut       <= '0;
         bestMetric <= '0;
      end else if (frame.ready) begin
         selOut     <= bestIdx;
         iOut       <= frame.iBranch[bestIdx];
         qOut       <= frame.qBranch[bestIdx];
         bestMetric <= bestSum;
      end
   end

   // output strobe marks the cycle the new survivor appears
   always_ff @(posedge clk) begin
      if (reset) begin
         symEnOut <= 1'b0;
      end else begin
         symEnOut <= frame.ready;
      end
   end

   // top bits 01 mean a positive metric close to wrapping
   assign normalizeOut = (bestMetric[AB-1 -: 2] == 2'b01);

   assign normDiff = $signed({bestMetric[AB-1], bestMetric}) - NORM_OFFSET;

   // when asked to normalize, pull the metric down and stop it at zero
   always_comb begin
      if (!normalizeIn) begin
         accMetOut = bestMetric;
      end else if (normDiff[AB]) begin
         accMetOut = '0;
      end else begin
         accMetOut = normDiff[AB-1:0];
      end
   end

endmodule

//--- src/branchCollector.sv
`timescale 1ns/1ps

module branchCollector (
   input  logic         clk,
   input  logic         reset,
   rotOutIf.sink        rotOut,
   branchFrameIf.source frame
);

   localparam int NB = cpmDemodPkg::NUM_BRANCHES;
   localparam cpmDemodPkg::branchIdx LAST = cpmDemodPkg::branchIdx'(NB - 1);

   // two banks so the ACS keeps a stable frame while the next symbol fills
   cpmDemodPkg::rotSample iStore [2][NB];
   cpmDemodPkg::rotSample qStore [2][NB];
   logic                  wrBank;
   logic                  lastWrite;

   assign lastWrite = rotOut.valid && (rotOut.branch == LAST);

   // each branch lands in the slot named by its tag
   always_ff @(posedge clk) begin
      if (rotOut.valid) begin
         iStore[wrBank][rotOut.branch] <= rotOut.i;
         qStore[wrBank][rotOut.branch] <= rotOut.q;
      end
   end

   // writing the last branch closes the frame and flips the banks
   always_ff @(posedge clk) begin
      if (reset) begin
         wrBank      <= 1'b0;
         frame.ready <= 1'b0;
      end else begin
         frame.ready <= lastWrite;
         if (lastWrite) begin
            wrBank <= ~wrBank;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (lastWrite) begin
         frame.parity <= rotOut.parity;
      end
   end

   // the bank not being written is always the last complete frame
   always_comb begin
      for (int k = 0; k < NB; k++) begin
         frame.iBranch[k] = iStore[~wrBank][k];
         frame.qBranch[k] = qStore[~wrBank][k];
      end
   end

endmodule

//--- src/branchSequencer.sv
`timescale 1ns/1ps

module branchSequencer #(
   parameter cpmDemodPkg::phaseIdx [cpmDemodPkg::NUM_BRANCHES-1:0] PHASE45 = '0,
   parameter cpmDemodPkg::phaseIdx [cpmDemodPkg::NUM_BRANCHES-1:0] PHASE54 = '0
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 symEn,
   input  logic                 symEnEven,
   input  cpmDemodPkg::rotAngle tilt,
   input  cpmDemodPkg::mfSample mfI45 [cpmDemodPkg::NUM_BRANCHES],
   input  cpmDemodPkg::mfSample mfI54 [cpmDemodPkg::NUM_BRANCHES],
   input  cpmDemodPkg::mfSample mfQ45 [cpmDemodPkg::NUM_BRANCHES],
   input  cpmDemodPkg::mfSample mfQ54 [cpmDemodPkg::NUM_BRANCHES],
   rotInIf.source               rotIn
);

   localparam int NB = cpmDemodPkg::NUM_BRANCHES;
   localparam int MSB = cpmDemodPkg::MF_BITS - 1;
   localparam int RB = cpmDemodPkg::ROT_BITS;

   // sample set held for the whole symbol, so the MF bank may move on right away
   cpmDemodPkg::mfSample mfI45R [NB];
   cpmDemodPkg::mfSample mfI54R [NB];
   cpmDemodPkg::mfSample mfQ45R [NB];
   cpmDemodPkg::mfSample mfQ54R [NB];
   cpmDemodPkg::rotAngle tiltR;
   logic                 parityR;

   cpmDemodPkg::seqState state;
   cpmDemodPkg::branchIdx branchCnt;

   cpmDemodPkg::mfSample iSel;
   cpmDemodPkg::mfSample qSel;
   cpmDemodPkg::phaseIdx phaseSel;
   cpmDemodPkg::rotAngle stepSum;

   // parity is taken together with the samples so it lines up with them
   always_ff @(posedge clk) begin
      if (symEn) begin
         mfI45R  <= mfI45;
         mfI54R  <= mfI54;
         mfQ45R  <= mfQ45;
         mfQ54R  <= mfQ54;
         tiltR   <= tilt;
         parityR <= symEnEven;
      end
   end

   // symEn always starts a fresh run from branch 0, even mid-symbol
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= cpmDemodPkg::SEQ_IDLE;
         branchCnt <= '0;
      end else if (symEn) begin
         state     <= cpmDemodPkg::SEQ_RUN;
         branchCnt <= '0;
      end else if (state == cpmDemodPkg::SEQ_RUN) begin
         // the counter wraps back to 0 on the last branch
         if (branchCnt == cpmDemodPkg::branchIdx'(NB - 1)) begin
            state <= cpmDemodPkg::SEQ_IDLE;
         end
         branchCnt <= branchCnt + 1'b1;
      end
   end

   always_comb begin
      // parity low picks the 45 set, parity high the 54 set
      if (parityR) begin
         iSel     = mfI54R[branchCnt];
         qSel     = mfQ54R[branchCnt];
         phaseSel = PHASE54[branchCnt];
      end else begin
         iSel     = mfI45R[branchCnt];
         qSel     = mfQ45R[branchCnt];
         phaseSel = PHASE45[branchCnt];
      end
      // each phase unit is worth two angle steps
      stepSum = tiltR + cpmDemodPkg::rotAngle'({phaseSel, 1'b0});
   end

   assign rotIn.valid  = (state == cpmDemodPkg::SEQ_RUN);
   assign rotIn.branch = branchCnt;
   assign rotIn.parity = parityR;
   // only the top bits of the MF sample go into the rotator
   assign rotIn.i      = iSel[MSB -: RB];
   assign rotIn.q      = qSel[MSB -: RB];
   // rotate backwards by tilt plus phase, the 5-bit wrap does the mod 32
   assign rotIn.angle  = '0 - stepSum;

endmodule

//--- src/cpmDemodPkg.sv
package cpmDemodPkg;

   // matched-filter output width as delivered by the MF bank
   localparam int MF_BITS = 10;
   // the rotator works on the top ROT_BITS of each MF sample
   localparam int ROT_BITS = 8;
   // accumulated path metric width, wraps on overflow
   localparam int ACS_BITS = 8;
   // branches per symbol, one per candidate phase state
   localparam int NUM_BRANCHES = 4;
   // one full turn of the rotator is split into this many steps
   localparam int ANGLE_STEPS = 32;
   // cycles from the symEn strobe to the symEnOut strobe
   // 1 capture + 4 serial branches + 2 rotator + 1 ACS register
   localparam int ACS_LATENCY = 8;

   // one matched-filter output sample
   typedef logic signed [MF_BITS-1:0] mfSample;
   // rotator input and output sample
   typedef logic signed [ROT_BITS-1:0] rotSample;
   // accumulated path metric
   typedef logic signed [ACS_BITS-1:0] acsMetric;
   // branch number, also the survivor select
   typedef logic [$clog2(NUM_BRANCHES)-1:0] branchIdx;
   // phase index theta(n-2), one unit is two angle steps
   typedef logic [3:0] phaseIdx;
   // rotation angle in steps of 2*pi/ANGLE_STEPS
   typedef logic [$clog2(ANGLE_STEPS)-1:0] rotAngle;

   // the sequencer is either idle or walking through the branches
   typedef enum logic {
      SEQ_IDLE,
      SEQ_RUN
   } seqState;

endpackage

//--- src/phaseRotator.sv
`timescale 1ns/1ps

module phaseRotator (
   input  logic    clk,
   input  logic    reset,
   rotInIf.sink    rotIn,
   rotOutIf.source rotOut
);

   localparam int RB = cpmDemodPkg::ROT_BITS;
   localparam int PW = 2 * RB;
   // sine is the cosine a quarter turn later
   localparam cpmDemodPkg::rotAngle SIN_OFFSET =
      cpmDemodPkg::rotAngle'(cpmDemodPkg::ANGLE_STEPS / 4);

   cpmDemodPkg::rotSample cosVal;
   cpmDemodPkg::rotSample sinVal;

   // stage one holds the four partial products
   logic signed [PW-1:0] prodIc;
   logic signed [PW-1:0] prodQs;
   logic signed [PW-1:0] prodIs;
   logic signed [PW-1:0] prodQc;
   logic                  valid1;
   cpmDemodPkg::branchIdx branch1;
   logic                  parity1;

   // one extra bit so the sum of two products cannot overflow
   logic signed [PW:0] iSum;
   logic signed [PW:0] qSum;

   // clamps a shifted sum into ROT_BITS
   function automatic cpmDemodPkg::rotSample saturate(input logic signed [PW:0] x);
      logic fits;
      // the value fits when all bits above the kept field match its sign
      fits = (&x[PW:RB-1]) | ~(|x[PW:RB-1]);
      if (fits) begin
         return x[RB-1:0];
      end
      return {x[PW], {(RB - 1){~x[PW]}}};
   endfunction

   assign cosVal = rotatorTablePkg::COS_TABLE[rotIn.angle];
   assign sinVal = rotatorTablePkg::COS_TABLE[cpmDemodPkg::rotAngle'(rotIn.angle - SIN_OFFSET)];

   always_ff @(posedge clk) begin
      prodIc  <= rotIn.i * cosVal;
      prodQs  <= rotIn.q * sinVal;
      prodIs  <= rotIn.i * sinVal;
      prodQc  <= rotIn.q * cosVal;
      branch1 <= rotIn.branch;
      parity1 <= rotIn.parity;
   end

   // the valid bits are the only control state in the rotator
   always_ff @(posedge clk) begin
      if (reset) begin
         valid1       <= 1'b0;
         rotOut.valid <= 1'b0;
      end else begin
         valid1       <= rotIn.valid;
         rotOut.valid <= valid1;
      end
   end

   // complex multiply by cos + j*sin, then drop the table gain
   assign iSum = (prodIc - prodQs) >>> rotatorTablePkg::ROT_SHIFT;
   assign qSum = (prodIs + prodQc) >>> rotatorTablePkg::ROT_SHIFT;

   always_ff @(posedge clk) begin
      rotOut.i      <= saturate(iSum);
      rotOut.q      <= saturate(qSum);
      rotOut.branch <= branch1;
      rotOut.parity <= parity1;
   end

endmodule

//--- src/rotatorTablePkg.sv
package rotatorTablePkg;

   // cosine over one turn scaled by 64, entry k is round(64*cos(2*pi*k/32))
   // the sine of angle k is the entry at (k - 8) mod 32
   localparam cpmDemodPkg::rotSample COS_TABLE [cpmDemodPkg::ANGLE_STEPS] = '{
      64,  63,  59,  53,  45,  36,  24,  12,
       0, -12, -24, -36, -45, -53, -59, -63,
     -64, -63, -59, -53, -45, -36, -24, -12,
       0,  12,  24,  36,  45,  53,  59,  63
   };

   // the table carries a gain of 64, so products are shifted down by six bits
   localparam int ROT_SHIFT = 6;

endpackage

//--- verif/acsMultiHTb.sv
`timescale 1ns/1ps

module acsMultiHTb;

   localparam int NB = cpmDemodPkg::NUM_BRANCHES;
   // a result is due ACS_LATENCY cycles after the strobe and twenty cycles leave plenty of slack
   localparam int RESULT_TIMEOUT = 20;
   localparam int NUM_FIELDS = 34;

   // the 54 phase set sits eight angle steps away from the 45 set
   localparam cpmDemodPkg::phaseIdx [NB-1:0] TB_PHASE45 = {4'd0, 4'd0, 4'd0, 4'd0};
   localparam cpmDemodPkg::phaseIdx [NB-1:0] TB_PHASE54 = {4'd4, 4'd4, 4'd4, 4'd4};

   logic                  clk;
   logic                  reset;
   logic                  symEn;
   logic                  symEnEven;
   cpmDemodPkg::rotAngle  tilt;
   cpmDemodPkg::mfSample  mfI45 [NB];
   cpmDemodPkg::mfSample  mfI54 [NB];
   cpmDemodPkg::mfSample  mfQ45 [NB];
   cpmDemodPkg::mfSample  mfQ54 [NB];
   cpmDemodPkg::acsMetric accMet45 [NB];
   cpmDemodPkg::acsMetric accMet54 [NB];
   logic                  normalizeIn;
   cpmDemodPkg::branchIdx selOut;
   cpmDemodPkg::rotSample iOut;
   cpmDemodPkg::rotSample qOut;
   cpmDemodPkg::acsMetric accMetOut;
   logic                  normalizeOut;
   logic                  symEnOut;

   // expected results of the symbols in flight with the oldest first
   string                 expName [$];
   cpmDemodPkg::branchIdx expSel [$];
   cpmDemodPkg::rotSample expI [$];
   cpmDemodPkg::rotSample expQ [$];
   cpmDemodPkg::acsMetric expAcc [$];
   logic                  expNorm [$];

   int mismatchCount;
   int otherErrors;
   int seed;

   acsMultiH #(
      .PHASE45 (TB_PHASE45),
      .PHASE54 (TB_PHASE54)
   ) u_dut (
      .clk          (clk),
      .reset        (reset),
      .symEn        (symEn),
      .symEnEven    (symEnEven),
      .tilt         (tilt),
      .mfI_45_0     (mfI45[0]),
      .mfI_45_1     (mfI45[1]),
      .mfI_45_2     (mfI45[2]),
      .mfI_45_3     (mfI45[3]),
      .mfI_54_0     (mfI54[0]),
      .mfI_54_1     (mfI54[1]),
      .mfI_54_2     (mfI54[2]),
      .mfI_54_3     (mfI54[3]),
      .mfQ_45_0     (mfQ45[0]),
      .mfQ_45_1     (mfQ45[1]),
      .mfQ_45_2     (mfQ45[2]),
      .mfQ_45_3     (mfQ45[3]),
      .mfQ_54_0     (mfQ54[0]),
      .mfQ_54_1     (mfQ54[1]),
      .mfQ_54_2     (mfQ54[2]),
      .mfQ_54_3     (mfQ54[3]),
      .accMet_45_0  (accMet45[0]),
      .accMet_45_1  (accMet45[1]),
      .accMet_45_2  (accMet45[2]),
      .accMet_45_3  (accMet45[3]),
      .accMet_54_0  (accMet54[0]),
      .accMet_54_1  (accMet54[1]),
      .accMet_54_2  (accMet54[2]),
      .accMet_54_3  (accMet54[3]),
      .normalizeIn  (normalizeIn),
      .selOut       (selOut),
      .iOut         (iOut),
      .qOut         (qOut),
      .accMetOut    (accMetOut),
      .normalizeOut (normalizeOut),
      .symEnOut     (symEnOut)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   task automatic checkIdx(input string name, input cpmDemodPkg::branchIdx expected,
                           input cpmDemodPkg::branchIdx actual);
      if (expected !== actual) begin
         $display("Mismatch %s selOut: expected %0d actual %0d", name, expected, actual);
         mismatchCount++;
      end
   endtask

   task automatic checkSample(input string name, input string port,
                              input cpmDemodPkg::rotSample expected,
                              input cpmDemodPkg::rotSample actual);
      if (expected !== actual) begin
         $display("Mismatch %s %s: expected %0d actual %0d", name, port, expected, actual);
         mismatchCount++;
      end
   endtask

   task automatic checkMetric(input string name, input cpmDemodPkg::acsMetric expected,
                              input cpmDemodPkg::acsMetric actual);
      if (expected !== actual) begin
         $display("Mismatch %s accMetOut: expected %0d actual %0d", name, expected, actual);
         mismatchCount++;
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (expected !== actual) begin
         $display("Mismatch %s normalizeOut: expected %b actual %b", name, expected, actual);
         mismatchCount++;
      end
   endtask

   // outputs settle after the rising edge and are sampled on the falling one
   initial begin
      string name;
      forever begin
         @(negedge clk);
         if (!reset && symEnOut) begin
            if (expName.size() == 0) begin
               $display("symEnOut pulsed while no symbol was pending");
               otherErrors++;
            end else begin
               name = expName.pop_front();
               checkIdx(name, expSel.pop_front(), selOut);
               checkSample(name, "iOut", expI.pop_front(), iOut);
               checkSample(name, "qOut", expQ.pop_front(), qOut);
               checkMetric(name, expAcc.pop_front(), accMetOut);
               checkFlag(name, expNorm.pop_front(), normalizeOut);
            end
         end
      end
   end

   // returns 0 when the pending results did not show up in time
   task automatic drainResults(input string name, output bit ok);
      int cycles;
      cycles = 0;
      while (expName.size() != 0 && cycles < RESULT_TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      ok = (expName.size() == 0);
      if (!ok) begin
         $display("Timeout in %s: symEnOut never arrived within %0d cycles",
                  name, RESULT_TIMEOUT);
         otherErrors++;
      end
   endtask

   // drives one symbol and queues what it should produce
   task automatic sendSymbol(input string name, input int v [NUM_FIELDS-1]);
      @(posedge clk);
      #2;
      tilt        = cpmDemodPkg::rotAngle'(v[0]);
      symEnEven   = v[1][0];
      normalizeIn = v[2][0];
      for (int k = 0; k < NB; k++) begin
         mfI45[k]    = cpmDemodPkg::mfSample'(v[4 + k]);
         mfI54[k]    = cpmDemodPkg::mfSample'(v[8 + k]);
         mfQ45[k]    = cpmDemodPkg::mfSample'(v[12 + k]);
         mfQ54[k]    = cpmDemodPkg::mfSample'(v[16 + k]);
         accMet45[k] = cpmDemodPkg::acsMetric'(v[20 + k]);
         accMet54[k] = cpmDemodPkg::acsMetric'(v[24 + k]);
         // the set that parity leaves out gets noise that must not reach the outputs
         if (v[1][0]) begin
            mfI45[k] = cpmDemodPkg::mfSample'($random(seed));
            mfQ45[k] = cpmDemodPkg::mfSample'($random(seed));
         end else begin
            mfI54[k] = cpmDemodPkg::mfSample'($random(seed));
            mfQ54[k] = cpmDemodPkg::mfSample'($random(seed));
         end
      end
      expName.push_back(name);
      expSel.push_back(cpmDemodPkg::branchIdx'(v[28]));
      expI.push_back(cpmDemodPkg::rotSample'(v[29]));
      expQ.push_back(cpmDemodPkg::rotSample'(v[30]));
      expAcc.push_back(cpmDemodPkg::acsMetric'(v[31]));
      expNorm.push_back(v[32][0]);
      symEn = 1'b1;
      @(posedge clk);
      #2;
      symEn = 1'b0;
   endtask

   initial begin
      int    fd;
      int    count;
      int    v [NUM_FIELDS-1];
      string line;
      string name;
      bit    ok;
      mismatchCount = 0;
      otherErrors   = 0;
      seed          = 32'h4109;
      ok            = 1'b1;
      reset         = 1'b1;
      symEn         = 1'b0;
      symEnEven     = 1'b0;
      normalizeIn   = 1'b0;
      tilt          = '0;
      for (int k = 0; k < NB; k++) begin
         mfI45[k]    = '0;
         mfI54[k]    = '0;
         mfQ45[k]    = '0;
         mfQ54[k]    = '0;
         accMet45[k] = '0;
         accMet54[k] = '0;
      end
      repeat (5) @(posedge clk);
      #2;
      reset = 1'b0;

      fd = $fopen("verif/acsMultiH_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file verif/acsMultiH_input.txt");
         otherErrors++;
         ok = 1'b0;
      end
      while (ok && !$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line.getc(0) == "#") begin
            continue;
         end
         // the test name followed by 33 whitespace separated hex fields
         count = $sscanf(line,
                         "%s%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                         name, v[0], v[1], v[2], v[3],
                         v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                         v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19],
                         v[20], v[21], v[22], v[23], v[24], v[25], v[26], v[27],
                         v[28], v[29], v[30], v[31], v[32]);
         if (count != NUM_FIELDS) begin
            $display("Stimulus line has %0d fields instead of %0d: %s", count, NUM_FIELDS, line);
            otherErrors++;
            continue;
         end
         sendSymbol(name, v);
         // a nonzero spacing issues the next symbol early so symbols overlap
         if (v[3] > 1) begin
            repeat (v[3] - 2) @(posedge clk);
         end else begin
            drainResults(name, ok);
         end
      end
      if (ok) begin
         drainResults("end of stimulus", ok);
      end
      if (fd != 0) begin
         $fclose(fd);
      end

      $display("Result: %0d mismatches, %0d other errors", mismatchCount, otherErrors);
      if (mismatchCount == 0 && otherErrors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- verif/acsMultiH_input.txt
# name tilt parity normIn spacing i45[0..3] i54[0..3] q45[0..3] q54[0..3] m45[0..3] m54[0..3]
# then expected selOut iOut qOut accMetOut normalizeOut, all hex, spacing 0 waits for the result
zero_angle 00 0 0 0 028 0a0 3b0 014 000 000 000 000 00c 3e4 024 02c 000 000 000 000 00 00 00 00 00 00 00 00 1 28 f9 28 0
rot8 18 0 0 0 004 008 00c 010 000 000 000 000 200 028 050 3ec 000 000 000 000 00 00 00 00 00 00 00 00 0 7f 01 7f 1
rot16 10 0 1 0 050 388 014 270 000 000 000 000 01c 020 3dc 0c8 000 000 000 000 0a 00 00 00 00 00 00 00 3 64 ce 44 1
rot24 08 0 1 0 004 008 00c 010 000 000 000 000 014 3e8 0f0 01c 000 000 000 000 00 00 00 00 00 00 00 00 2 3c fd 1c 0
rot_odd 1f 0 0 0 100 028 3d8 000 000 000 000 000 080 000 000 000 000 000 000 000 00 00 00 00 00 00 00 00 0 39 2b 39 0
par45 00 0 0 0 014 018 01c 020 014 018 01c 020 004 008 00c 010 0a0 3f4 008 004 00 00 00 14 00 0a 00 00 3 08 04 1c 0
par54 00 1 0 0 014 018 01c 020 014 018 01c 020 004 008 00c 010 0a0 3f4 008 004 00 00 00 14 00 0a 00 00 0 28 fb 28 0
tie_neg 00 0 1 0 338 3b0 3b0 310 000 000 000 000 004 008 00c 010 000 000 000 000 00 00 00 00 00 00 00 00 1 ec 02 00 0
wrap 00 0 0 0 190 028 000 3fc 000 000 000 000 000 000 000 014 000 000 000 000 64 78 80 00 00 00 00 00 3 ff 05 ff 0
norm 00 0 1 0 000 000 000 000 000 000 000 000 024 000 000 000 000 000 000 000 50 20 00 00 00 00 00 00 0 00 09 30 1
ov0 00 0 0 4 004 008 00c 010 000 000 000 000 02c 030 034 038 000 000 000 000 00 00 00 00 00 00 00 00 3 04 0e 04 0
ov1 00 0 0 4 078 008 00c 010 000 000 000 000 054 058 05c 060 000 000 000 000 00 00 00 00 00 00 00 00 0 1e 15 1e 0
ov2 00 0 0 0 004 0c8 00c 010 000 000 000 000 07c 080 084 088 000 000 000 000 00 00 00 00 00 00 00 00 1 32 20 32 0

//--- verif/acsMultiH_properties.sv
`timescale 1ns/1ps

module acsMultiH_properties (
   input logic clk,
   input logic reset,
   input logic symEn,
   input logic symEnOut,
   input logic rotValid,
   input logic normalizeOut
);

   // the output strobe is the input strobe delayed by the full pipeline
   symEnLatency: assert property (@(posedge clk) disable iff (reset)
      symEnOut == $past(symEn, cpmDemodPkg::ACS_LATENCY))
      else $error("symEnOut is not symEn delayed by ACS_LATENCY cycles");

   // the flag only moves together with a new survivor marked by symEnOut
   normalizeHold: assert property (@(posedge clk) disable iff (reset)
      !symEnOut |-> $stable(normalizeOut))
      else $error("normalizeOut changed while no new survivor was presented");

   // each strobe opens a window of four branches into the rotator
   rotValidWindow: assert property (@(posedge clk) disable iff (reset)
      rotValid == ($past(symEn, 1) || $past(symEn, 2) || $past(symEn, 3) || $past(symEn, 4)))
      else $error("rotator valid is not high for exactly four cycles per symbol");

endmodule

bind acsMultiH acsMultiH_properties u_props (
   .clk          (clk),
   .reset        (reset),
   .symEn        (symEn),
   .symEnOut     (symEnOut),
   .rotValid     (rotIn.valid),
   .normalizeOut (normalizeOut)
);
